// File: dbg_uart_cfg.svh
/* Build-time settings of the UART debug server: bit timing, memory size, exec width */

`ifndef DBG_UART_CFG_SVH
`define DBG_UART_CFG_SVH

////////////////////////////////////////////////////
// Serial line
////////////////////////////////////////////////////

// clk cycles per UART bit, at least 2
`define DBG_CLKS_PER_BIT 8

////////////////////////////////////////////////////
// Target resources
////////////////////////////////////////////////////

// Byte memory and its index width, kept in step
`define DBG_MEM_BYTES 256
`define DBG_MEM_AW 8

// Width of the exec entry address output
`define DBG_EXEC_AW 32

`endif

// File: dbg_uart_pkg.sv
/* Protocol byte codes, engine states and the byte type of the UART debug server */

package dbg_uart_pkg;

  // One UART payload byte
  typedef logic [7:0] dbg_byte_t;

  // Bytes on the wire, as the host tools expect them
  typedef enum logic [7:0] {
    EOT       = 8'h04,
    ACK       = 8'h06,
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12,
    CMD_EXEC  = 8'h13,
    EOC       = 8'h14
  } dbg_code_e;

  // Command engine FSM
  typedef enum logic [3:0] {
    IDLE,
    FIELD,
    SEND_ACK,
    DATA_RX,
    DATA_TX,
    SEND_EOT,
    EOC_CODE
  } dbg_state_e;

endpackage

// File: dbg_uart_rx.sv
/* UART receiver: 8N1 frames from the serial line to one-cycle byte strobes */

`timescale 1ns/1ps

`include "dbg_uart_cfg.svh"

module dbg_uart_rx (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   uart_rx_i,
  output dbg_uart_pkg::dbg_byte_t rx_data_o,
  output logic                   rx_valid_o
);

  import dbg_uart_pkg::*;

  localparam int clks_per_bit = `DBG_CLKS_PER_BIT;
  localparam int cnt_w        = $clog2(clks_per_bit);

  localparam logic [cnt_w-1:0] cnt_half = cnt_w'(clks_per_bit / 2 - 1);
  localparam logic [cnt_w-1:0] cnt_full = cnt_w'(clks_per_bit - 1);

  logic [1:0]       sync_q;
  logic             line;
  logic             busy_q;
  logic [cnt_w-1:0] cnt_q;
  // 0 is the start bit, 1 to 8 data, 9 the stop bit
  logic [3:0]       bit_q;
  dbg_byte_t        shift_q;

  // Line after the two-flop synchronizer
  assign line      = sync_q[1];
  assign rx_data_o = shift_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      sync_q     <= 2'b11;
      busy_q     <= 1'b0;
      cnt_q      <= '0;
      bit_q      <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      sync_q     <= {sync_q[0], uart_rx_i};
      rx_valid_o <= 1'b0;
      if (!busy_q) begin
        // Falling start edge, first sample half a bit later
        if (!line) begin
          busy_q <= 1'b1;
          cnt_q  <= cnt_half;
          bit_q  <= '0;
        end
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end else begin
        cnt_q <= cnt_full;
        bit_q <= bit_q + 1'b1;
        if (bit_q == 4'd0) begin
          // Glitch, not a real start bit
          if (line) busy_q <= 1'b0;
        end else if (bit_q == 4'd9) begin
          busy_q     <= 1'b0;
          // Framing error drops the byte
          rx_valid_o <= line;
        end
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (busy_q && cnt_q == '0 && bit_q != 4'd0 && bit_q != 4'd9) begin
      shift_q <= {line, shift_q[7:1]};
    end
  end

endmodule

// File: dbg_uart_tx.sv
/* UART transmitter: one 8N1 frame per accepted byte, ready while idle */

`timescale 1ns/1ps

`include "dbg_uart_cfg.svh"

module dbg_uart_tx (
  input  logic                    clk,
  input  logic                    reset_i,
  input  dbg_uart_pkg::dbg_byte_t tx_data_i,
  input  logic                    tx_valid_i,
  output logic                    tx_ready_o,
  output logic                    uart_tx_o
);

  import dbg_uart_pkg::*;

  localparam int clks_per_bit = `DBG_CLKS_PER_BIT;
  localparam int cnt_w        = $clog2(clks_per_bit);

  localparam logic [cnt_w-1:0] cnt_full = cnt_w'(clks_per_bit - 1);

  logic             busy_q;
  logic [cnt_w-1:0] cnt_q;
  // Bits still to go after the one on the line
  logic [3:0]       bits_q;
  logic [9:0]       frame_q;

  assign tx_ready_o = ~busy_q;
  assign uart_tx_o  = busy_q ? frame_q[0] : 1'b1;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      bits_q <= '0;
    end else if (!busy_q) begin
      if (tx_valid_i) begin
        busy_q <= 1'b1;
        cnt_q  <= cnt_full;
        bits_q <= 4'd9;
      end
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end else if (bits_q == '0) begin
      // Stop bit done
      busy_q <= 1'b0;
    end else begin
      cnt_q  <= cnt_full;
      bits_q <= bits_q - 1'b1;
    end
  end

  // Stop, data LSB first, start
  always_ff @(posedge clk) begin
    if (!busy_q && tx_valid_i) begin
      frame_q <= {1'b1, tx_data_i, 1'b0};
    end else if (busy_q && cnt_q == '0) begin
      frame_q <= {1'b1, frame_q[9:1]};
    end
  end

endmodule

// File: dbg_cmd_engine.sv
/* Debug command engine: ACK challenge, memory read/write, exec strobe, EOC report */

`timescale 1ns/1ps

`include "dbg_uart_cfg.svh"

module dbg_cmd_engine (
  input  logic                    clk,
  input  logic                    reset_i,
  input  dbg_uart_pkg::dbg_byte_t rx_data_i,
  input  logic                    rx_valid_i,
  output dbg_uart_pkg::dbg_byte_t tx_data_o,
  output logic                    tx_valid_o,
  input  logic                    tx_ready_i,
  output logic                    exec_valid_o,
  output logic [`DBG_EXEC_AW-1:0] exec_addr_o,
  input  logic                    eoc_i,
  input  logic [31:0]             exit_code_i
);

  import dbg_uart_pkg::*;

  dbg_state_e            state_q;
  dbg_code_e             cmd_q;
  logic [3:0]            field_cnt_q;
  logic [2:0]            eoc_cnt_q;
  logic                  eoc_pend_q;
  logic                  wr_en_q;
  logic                  tx_fire;
  logic [63:0]           addr_q;
  logic [63:0]           addr_nxt;
  logic [63:0]           len_q;
  logic [`DBG_MEM_AW-1:0] idx_q;
  dbg_byte_t             wr_data_q;
  logic [31:0]           exit_code_q;
  logic [39:0]           eoc_word_q;
  dbg_byte_t             mem_q [`DBG_MEM_BYTES];

  // Fields are little endian, newest byte enters at the top
  assign addr_nxt = {rx_data_i, addr_q[63:8]};
  assign tx_fire  = tx_valid_o & tx_ready_i;

  ////////////////////////////////////////////////////
  // Reply byte
  ////////////////////////////////////////////////////

  always_comb begin
    tx_valid_o = 1'b1;
    case (state_q)
      SEND_ACK: tx_data_o = ACK;
      DATA_TX:  tx_data_o = mem_q[idx_q];
      SEND_EOT: tx_data_o = EOT;
      EOC_CODE: tx_data_o = eoc_word_q[7:0];
      default: begin
        tx_data_o  = ACK;
        tx_valid_o = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q      <= IDLE;
      field_cnt_q  <= '0;
      eoc_cnt_q    <= '0;
      eoc_pend_q   <= 1'b0;
      exec_valid_o <= 1'b0;
      wr_en_q      <= 1'b0;
    end else begin
      exec_valid_o <= 1'b0;
      wr_en_q      <= 1'b0;
      if (eoc_i) eoc_pend_q <= 1'b1;
      case (state_q)
        IDLE: begin
          if (eoc_pend_q) begin
            state_q    <= EOC_CODE;
            eoc_cnt_q  <= '0;
            eoc_pend_q <= eoc_i;
          end else if (rx_valid_i) begin
            // Anything else is ignored
            case (rx_data_i)
              ACK: state_q <= SEND_ACK;
              CMD_READ, CMD_WRITE, CMD_EXEC: begin
                state_q     <= FIELD;
                field_cnt_q <= '0;
              end
              default: ;
            endcase
          end
        end
        FIELD: begin
          if (rx_valid_i) begin
            field_cnt_q <= field_cnt_q + 1'b1;
            // Exec carries the address only
            if ((cmd_q == CMD_EXEC && field_cnt_q == 4'd7) || field_cnt_q == 4'd15) begin
              state_q      <= SEND_ACK;
              exec_valid_o <= (cmd_q == CMD_EXEC);
            end
          end
        end
        SEND_ACK: begin
          if (tx_fire) begin
            if (cmd_q != CMD_READ && cmd_q != CMD_WRITE) begin
              state_q <= IDLE;
            end else if (len_q == '0) begin
              state_q <= SEND_EOT;
            end else begin
              state_q <= (cmd_q == CMD_READ) ? DATA_TX : DATA_RX;
            end
          end
        end
        DATA_RX: begin
          if (rx_valid_i) begin
            wr_en_q <= 1'b1;
            if (len_q == 64'd1) state_q <= SEND_EOT;
          end
        end
        DATA_TX: begin
          if (tx_fire && len_q == 64'd1) state_q <= SEND_EOT;
        end
        SEND_EOT: begin
          if (tx_fire) state_q <= IDLE;
        end
        EOC_CODE: begin
          // EOC then four code bytes
          if (tx_fire) begin
            eoc_cnt_q <= eoc_cnt_q + 1'b1;
            if (eoc_cnt_q == 3'd4) state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////
  // Fields, index and payload
  ////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (eoc_i) exit_code_q <= exit_code_i;
    // Index moves on once the buffered byte is stored
    if (wr_en_q) idx_q <= idx_q + 1'b1;
    case (state_q)
      IDLE: begin
        if (eoc_pend_q) begin
          eoc_word_q <= {exit_code_q, EOC};
        end else if (rx_valid_i) begin
          cmd_q <= dbg_code_e'(rx_data_i);
        end
      end
      FIELD: begin
        if (rx_valid_i) begin
          if (field_cnt_q < 4'd8) addr_q <= addr_nxt;
          else len_q <= {rx_data_i, len_q[63:8]};
          if (cmd_q == CMD_EXEC && field_cnt_q == 4'd7) begin
            exec_addr_o <= addr_nxt[`DBG_EXEC_AW-1:0];
          end
          // Upper address bits are dropped
          if (field_cnt_q == 4'd15) idx_q <= addr_q[`DBG_MEM_AW-1:0];
        end
      end
      DATA_RX: begin
        if (rx_valid_i) begin
          wr_data_q <= rx_data_i;
          len_q     <= len_q - 1'b1;
        end
      end
      DATA_TX: begin
        if (tx_fire) begin
          idx_q <= idx_q + 1'b1;
          len_q <= len_q - 1'b1;
        end
      end
      EOC_CODE: begin
        if (tx_fire) eoc_word_q <= {8'h00, eoc_word_q[39:8]};
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (wr_en_q) mem_q[idx_q] <= wr_data_q;
  end

endmodule

// File: dbg_uart_top.sv
/* UART debug server top: receiver, transmitter and command engine */

`timescale 1ns/1ps

`include "dbg_uart_cfg.svh"

module dbg_uart_top (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    uart_rx_i,
  output logic                    uart_tx_o,
  output logic                    exec_valid_o,
  output logic [`DBG_EXEC_AW-1:0] exec_addr_o,
  input  logic                    eoc_i,
  input  logic [31:0]             exit_code_i
);

  import dbg_uart_pkg::*;

  dbg_byte_t rx_data;
  logic      rx_valid;
  dbg_byte_t tx_data;
  logic      tx_valid;
  logic      tx_ready;

  // Serial line in
  dbg_uart_rx i_rx (
    .clk        ( clk       ),
    .reset_i    ( reset_i   ),
    .uart_rx_i  ( uart_rx_i ),
    .rx_data_o  ( rx_data   ),
    .rx_valid_o ( rx_valid  )
  );

  // Serial line out
  dbg_uart_tx i_tx (
    .clk        ( clk       ),
    .reset_i    ( reset_i   ),
    .tx_data_i  ( tx_data   ),
    .tx_valid_i ( tx_valid  ),
    .tx_ready_o ( tx_ready  ),
    .uart_tx_o  ( uart_tx_o )
  );

  dbg_cmd_engine i_engine (
    .clk          ( clk          ),
    .reset_i      ( reset_i      ),
    .rx_data_i    ( rx_data      ),
    .rx_valid_i   ( rx_valid     ),
    .tx_data_o    ( tx_data      ),
    .tx_valid_o   ( tx_valid     ),
    .tx_ready_i   ( tx_ready     ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  ),
    .eoc_i        ( eoc_i        ),
    .exit_code_i  ( exit_code_i  )
  );

endmodule

// File: dbg_uart_asserts.sv
/* Bound checks on the debug server top: exec pulse width, idle line, reply handshake */

`timescale 1ns/1ps

module dbg_uart_asserts (
  input logic                     clk,
  input logic                     reset_i,
  input logic                     exec_valid_i,
  input logic                     uart_tx_i,
  input logic                     tx_valid_i,
  input logic                     tx_ready_i,
  input dbg_uart_pkg::dbg_state_e state_i
);

  int unsigned exec_fails = 0;
  int unsigned line_fails = 0;
  int unsigned hold_fails = 0;
  int unsigned fail_count;

  assign fail_count = exec_fails + line_fails + hold_fails;

  // Exec strobe lasts one cycle
  exec_pulse_a: assert property (@(posedge clk) disable iff (reset_i)
    exec_valid_i |=> !exec_valid_i)
    else begin
      $error("exec_valid_o high for two cycles in a row");
      exec_fails++;
    end

  // Line high while ready and in the last stop bit cycle before it
  idle_line_a: assert property (@(posedge clk) disable iff (reset_i)
    tx_ready_i |-> uart_tx_i && $past(uart_tx_i))
    else begin
      $error("uart_tx_o low while the transmitter is ready or just before it");
      line_fails++;
    end

  // Reply byte held in the same state until taken
  tx_hold_a: assert property (@(posedge clk) disable iff (reset_i)
    tx_valid_i && !tx_ready_i |=> tx_valid_i && state_i == $past(state_i))
    else begin
      $error("engine tx_valid dropped before it was accepted");
      hold_fails++;
    end

endmodule

bind dbg_uart_top dbg_uart_asserts i_asserts (
  .clk          ( clk              ),
  .reset_i      ( reset_i          ),
  .exec_valid_i ( exec_valid_o     ),
  .uart_tx_i    ( uart_tx_o        ),
  .tx_valid_i   ( tx_valid         ),
  .tx_ready_i   ( tx_ready         ),
  .state_i      ( i_engine.state_q )
);

// File: tb_dbg_uart.sv
/* Testbench for the UART debug server: serial byte tasks, LFSR stimulus,
   protocol checks and watchdog */

`timescale 1ns/1ps

`include "dbg_uart_cfg.svh"

module tb_dbg_uart;

  import dbg_uart_pkg::*;

  localparam int cpb    = `DBG_CLKS_PER_BIT;
  localparam int mem_aw = `DBG_MEM_AW;
  // Frames on either line over all tests, counted as if back to back
  localparam int total_frames = 3 + 27 + 27 + 10 + 5 + 5;
  localparam int timeout_ns   = total_frames * 10 * cpb * 8 * 2;

  logic                    clk;
  logic                    reset_i;
  logic                    uart_rx_i;
  logic                    uart_tx_o;
  logic                    exec_valid_o;
  logic [`DBG_EXEC_AW-1:0] exec_addr_o;
  logic                    eoc_i;
  logic [31:0]             exit_code_i;

  logic [31:0]             lfsr_state = 32'h8edb_3f94;
  logic [7:0]              rx_q[$];
  int                      rd_idx       = 0;
  int                      checks       = 0;
  int                      errors       = 0;
  int                      frame_errors = 0;
  int                      exec_cnt     = 0;
  logic [`DBG_EXEC_AW-1:0] exec_addr_seen;
  // Expected memory contents, written as the host writes them
  logic [7:0]              ref_mem [`DBG_MEM_BYTES];

  dbg_uart_top i_dbg_uart_top (
    .clk          ( clk          ),
    .reset_i      ( reset_i      ),
    .uart_rx_i    ( uart_rx_i    ),
    .uart_tx_o    ( uart_tx_o    ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  ),
    .eoc_i        ( eoc_i        ),
    .exit_code_i  ( exit_code_i  )
  );

  always #4 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], next_bit()};
    end
    return v;
  endfunction

  //////////////////////////////////////////////////
  // Serial line tasks
  //////////////////////////////////////////////////

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      uart_rx_i = frame[i];
      repeat (cpb - 1) @(negedge clk);
    end
  endtask

  // Little endian, 8 bytes
  task automatic send_field(input logic [63:0] v);
    for (int i = 0; i < 8; i++) begin
      send_byte(v[8*i +: 8]);
    end
  endtask

  task automatic recv_byte(output logic [7:0] b, output logic stop_ok);
    logic started;
    started = 1'b0;
    b = '0;
    while (!started) begin
      @(negedge clk);
      if (uart_tx_o == 1'b0) begin
        repeat (cpb / 2) @(negedge clk);
        started = (uart_tx_o == 1'b0);
      end
    end
    for (int i = 0; i < 8; i++) begin
      repeat (cpb) @(negedge clk);
      b[i] = uart_tx_o;
    end
    repeat (cpb) @(negedge clk);
    stop_ok = uart_tx_o;
  endtask

  // Next reply byte against the protocol's expected byte
  task automatic check_byte(input logic [7:0] exp, input string what);
    logic [7:0] got;
    while (rx_q.size() <= rd_idx) @(negedge clk);
    got = rx_q[rd_idx];
    rd_idx++;
    checks++;
    assert (got == exp) else begin
      $display("FAILED at %0d ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
      errors++;
    end
  endtask

  initial begin : reply_monitor
    logic [7:0] b;
    logic       stop_ok;
    while (reset_i !== 1'b0) @(negedge clk);
    forever begin
      recv_byte(b, stop_ok);
      assert (stop_ok) else begin
        $display("FAILED at %0d ns: stop bit of reply 0x%02h is low", $time, b);
        frame_errors++;
      end
      rx_q.push_back(b);
    end
  end

  always @(negedge clk) begin
    if (exec_valid_o === 1'b1) begin
      exec_cnt++;
      exec_addr_seen = exec_addr_o;
    end
  end

  initial begin : watchdog
    #(timeout_ns);
    $display("Timeout: the tests did not finish within %0d ns", timeout_ns);
    $display("*** FAILED ***");
    $finish;
  end

  //////////////////////////////////////////////////
  // Stimulus and checks
  //////////////////////////////////////////////////

  initial begin : stimulus
    logic [63:0]       r;
    logic [63:0]       addr;
    logic [31:0]       code;
    logic [mem_aw-1:0] mem_idx;
    int                len;
    int                exec_before;
    int                total;
    clk         = 1'b0;
    reset_i     = 1'b1;
    uart_rx_i   = 1'b1;
    eoc_i       = 1'b0;
    exit_code_i = '0;
    repeat (8) @(negedge clk);
    reset_i = 1'b0;
    repeat (4) @(negedge clk);

    // ACK challenge
    send_byte(ACK);
    check_byte(ACK, "challenge reply");

    // Write, length 4 to 8
    r    = rand_bits(64);
    addr = r;
    r    = rand_bits(3);
    len  = 4 + int'(r[2:0]) % 5;
    send_byte(CMD_WRITE);
    send_field(addr);
    send_field(64'(len));
    for (int i = 0; i < len; i++) begin
      r       = rand_bits(8);
      mem_idx = addr[mem_aw-1:0] + mem_aw'(i);
      ref_mem[mem_idx] = r[7:0];
      send_byte(r[7:0]);
    end
    check_byte(ACK, "write ACK");
    check_byte(EOT, "write EOT");

    // Read back the same range
    send_byte(CMD_READ);
    send_field(addr);
    send_field(64'(len));
    check_byte(ACK, "read ACK");
    for (int i = 0; i < len; i++) begin
      mem_idx = addr[mem_aw-1:0] + mem_aw'(i);
      check_byte(ref_mem[mem_idx], "read data byte");
    end
    check_byte(EOT, "read EOT");

    // Exec
    exec_before = exec_cnt;
    r = rand_bits(64);
    send_byte(CMD_EXEC);
    send_field(r);
    check_byte(ACK, "exec ACK");
    checks++;
    assert (exec_cnt == exec_before + 1 && exec_addr_seen == r[`DBG_EXEC_AW-1:0]) else begin
      $display("FAILED at %0d ns: %0d exec pulses at 0x%h, expected one at 0x%h",
               $time, exec_cnt - exec_before, exec_addr_seen, r[`DBG_EXEC_AW-1:0]);
      errors++;
    end

    // End of computation
    r    = rand_bits(32);
    code = r[31:0];
    @(negedge clk);
    exit_code_i = code;
    eoc_i       = 1'b1;
    @(negedge clk);
    eoc_i = 1'b0;
    check_byte(EOC, "EOC code");
    for (int i = 0; i < 4; i++) begin
      check_byte(code[8*i +: 8], "exit code byte");
    end

    // Unknown byte is ignored
    send_byte(8'h55);
    send_byte(ACK);
    check_byte(ACK, "challenge after unknown byte");
    repeat (20 * cpb) @(negedge clk);
    checks++;
    assert (rx_q.size() == rd_idx) else begin
      $display("FAILED at %0d ns: %0d extra reply bytes", $time, rx_q.size() - rd_idx);
      errors++;
    end

    total = errors + frame_errors + int'(i_dbg_uart_top.i_asserts.fail_count);
    $display("Checks: %0d, value errors: %0d, framing errors: %0d, assertion failures: %0d",
             checks, errors, frame_errors, i_dbg_uart_top.i_asserts.fail_count);
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: dbg_uart_top.f
+incdir+.
dbg_uart_pkg.sv
dbg_uart_rx.sv
dbg_uart_tx.sv
dbg_cmd_engine.sv
dbg_uart_top.sv
dbg_uart_asserts.sv
tb_dbg_uart.sv

// File: Makefile
# Verilator build and run of the UART debug server testbench

VERILATOR ?= verilator
TOP       ?= tb_dbg_uart
FILELIST  ?= dbg_uart_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** PASSED ***

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard *.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
